// File: compile.f
common/muldiv_pkg.sv
rtl/tag_buffer.sv
muldiv/mul_pipe.sv
muldiv/serial_div.sv
muldiv/muldiv_unit.sv
dv/muldiv_assert.sv
dv/muldiv_tb.sv

// File: Makefile
SIM  := obj_dir/Vmuldiv_tb
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module muldiv_tb -Mdir obj_dir -o Vmuldiv_tb -f compile.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/muldiv_tb.sv
`timescale 1ns/100ps

module muldiv_tb;

    localparam int  nl         = muldiv_pkg::num_lanes;
    localparam int  dw         = nl * 32;
    localparam int  n_random   = 260;
    localparam int  max_cycles = 15000;
    localparam real drive_dly  = 0.5;

    typedef struct packed {
        logic [muldiv_pkg::nw_bits-1:0] wid;
        logic [nl-1:0]                  tmask;
        logic [muldiv_pkg::nr_bits-1:0] rd;
        logic                           wb;
    } meta_t;

    logic                           clk;
    logic                           rst_n;
    logic                           req_valid;
    logic                           req_ready;
    muldiv_pkg::mul_op_t            req_op;
    logic [muldiv_pkg::nw_bits-1:0] req_wid;
    logic [nl-1:0]                  req_tmask;
    logic [31:0]                    req_pc;
    logic [muldiv_pkg::nr_bits-1:0] req_rd;
    logic                           req_wb;
    logic [dw-1:0]                  req_rs1;
    logic [dw-1:0]                  req_rs2;
    logic                           cmt_valid;
    logic                           cmt_ready;
    logic [muldiv_pkg::nw_bits-1:0] cmt_wid;
    logic [nl-1:0]                  cmt_tmask;
    logic [31:0]                    cmt_pc;
    logic [muldiv_pkg::nr_bits-1:0] cmt_rd;
    logic                           cmt_wb;
    logic [dw-1:0]                  cmt_data;

    integer      req_seed  = 9;
    integer      rdy_seed  = 9;
    int          bp_mode   = 0;
    int          n_commits = 0;
    int          cycles    = 0;
    logic [31:0] next_pc   = 32'h0000_1000;
    logic [31:0] last_pc;
    logic [31:0] corner [4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

    // Expected results keyed by PC
    logic [dw-1:0] exp_data  [logic [31:0]];
    meta_t         exp_meta  [logic [31:0]];
    int            commit_no [logic [31:0]];

    muldiv_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RISC-V M semantics, one 32-bit lane
    function automatic logic [31:0] lane_result(input muldiv_pkg::mul_op_t op,
                                                input logic [31:0] a, input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        p  = 64'h0;
        case (op)
            muldiv_pkg::op_mul:    p = {32'h0, 32'(ua * ub)};
            muldiv_pkg::op_mulh:   p = sa * sb;
            muldiv_pkg::op_mulhsu: p = sa * ub;
            muldiv_pkg::op_mulhu:  p = ua * ub;
            muldiv_pkg::op_div: begin
                if (b == 32'h0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
                return $signed(a) / $signed(b);
            end
            muldiv_pkg::op_divu:   return (b == 32'h0) ? 32'hffff_ffff : a / b;
            muldiv_pkg::op_rem: begin
                if (b == 32'h0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
                return $signed(a) % $signed(b);
            end
            default:               return (b == 32'h0) ? a : a % b;
        endcase
        return (op == muldiv_pkg::op_mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(req_seed);
        if (r[1:0] == 2'b00) return corner[r[5:4]];
        return $random(req_seed);
    endfunction

    task automatic stop_failed();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input logic [dw-1:0] expv,
                            input logic [dw-1:0] gotv);
        $display("FAIL %s expected %h got %h", name, expv, gotv);
        stop_failed();
    endtask

    task automatic offer(input muldiv_pkg::mul_op_t op, input logic [dw-1:0] a,
                         input logic [dw-1:0] b);
        logic [31:0]   r;
        meta_t         m;
        logic [dw-1:0] d;
        r = $random(req_seed);
        m = r[$bits(meta_t)-1:0];
        for (int i = 0; i < nl; i++) begin
            d[32*i +: 32] = lane_result(op, a[32*i +: 32], b[32*i +: 32]);
        end
        exp_data[next_pc] = d;
        exp_meta[next_pc] = m;
        {req_wid, req_tmask, req_rd, req_wb} = m;
        req_op    = op;
        req_rs1   = a;
        req_rs2   = b;
        req_pc    = next_pc;
        req_valid = 1'b1;
        last_pc   = next_pc;
        next_pc   = next_pc + 32'd4;
    endtask

    task automatic wait_accept();
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #drive_dly;
        req_valid = 1'b0;
    endtask

    task automatic send(input muldiv_pkg::mul_op_t op, input logic [dw-1:0] a,
                        input logic [dw-1:0] b);
        offer(op, a, b);
        wait_accept();
    endtask

    task automatic drain();
        @(posedge clk);
        while (exp_data.num() != 0) @(posedge clk);
        #drive_dly;
    endtask

    task automatic check_commit();
        meta_t m;
        assert (exp_data.exists(cmt_pc)) else begin
            $display("Commit for PC %h that was never sent or already returned", cmt_pc);
            stop_failed();
        end
        m = exp_meta[cmt_pc];
        assert (cmt_data == exp_data[cmt_pc])
            else mismatch("cmt_data", exp_data[cmt_pc], cmt_data);
        assert (cmt_wid == m.wid) else mismatch("cmt_wid", dw'(m.wid), dw'(cmt_wid));
        assert (cmt_tmask == m.tmask) else mismatch("cmt_tmask", dw'(m.tmask), dw'(cmt_tmask));
        assert (cmt_rd == m.rd) else mismatch("cmt_rd", dw'(m.rd), dw'(cmt_rd));
        assert (cmt_wb == m.wb) else mismatch("cmt_wb", dw'(m.wb), dw'(cmt_wb));
        commit_no[cmt_pc] = n_commits;
        n_commits++;
        exp_data.delete(cmt_pc);
        exp_meta.delete(cmt_pc);
    endtask

    // Handshake is decided at the next rising edge, so mid-cycle values are final
    always @(negedge clk) begin
        if (rst_n && cmt_valid && cmt_ready) begin
            check_commit();
        end
    end

    // Mode 0 keeps cmt_ready high, mode 1 drives random bursts and mode 2 holds it low
    initial begin
        int          run;
        logic [31:0] r;
        logic        rdy;
        rdy = 1'b1;
        cmt_ready = 1'b1;
        run = 0;
        forever begin
            @(posedge clk);
            if (bp_mode == 0) begin
                rdy = 1'b1;
            end else if (bp_mode == 2) begin
                rdy = 1'b0;
            end else begin
                if (run == 0) begin
                    r = $random(rdy_seed);
                    rdy = r[0];
                    run = 1 + int'(r[4:1]);
                end
                run--;
            end
            #drive_dly;
            cmt_ready = rdy;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            cycles++;
            assert (!u_dut.u_assert.any_failed) else begin
                $display("A bound protocol assertion fired");
                stop_failed();
            end
            assert (cycles < max_cycles) else begin
                $display("Timeout with %0d results outstanding", exp_data.num());
                stop_failed();
            end
        end
    end

    initial begin
        logic [dw-1:0] a;
        logic [dw-1:0] b;
        logic [31:0]   r;
        logic [31:0]   div_pc;
        logic [31:0]   mul_pc;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = muldiv_pkg::op_mul;
        {req_wid, req_tmask, req_pc, req_rd, req_wb} = '0;
        req_rs1   = '0;
        req_rs2   = '0;
        repeat (10) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;
        repeat (8) @(posedge clk);
        #drive_dly;

        // Every op against each pair of corner operands
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < 4; k++) begin
                for (int i = 0; i < nl; i++) begin
                    a[32*i +: 32] = corner[k];
                    b[32*i +: 32] = corner[i % 4];
                end
                send(muldiv_pkg::mul_op_t'(op[2:0]), a, b);
            end
        end
        drain();

        // A multiply behind a divide overtakes it
        a = {nl{32'h0000_1234}};
        b = {nl{32'h0000_0007}};
        send(muldiv_pkg::op_divu, a, b);
        div_pc = last_pc;
        send(muldiv_pkg::op_mul, a, b);
        mul_pc = last_pc;
        drain();
        assert (commit_no[mul_pc] < commit_no[div_pc]) else begin
            $display("Multiply accepted after a divide did not commit ahead of it");
            stop_failed();
        end

        bp_mode = 1;
        for (int n = 0; n < n_random; n++) begin
            r = $random(req_seed);
            for (int i = 0; i < nl; i++) begin
                a[32*i +: 32] = pick_operand();
                b[32*i +: 32] = pick_operand();
            end
            send(muldiv_pkg::mul_op_t'(r[2:0]), a, b);
        end
        drain();

        // With the output held off the unit stops taking requests
        bp_mode = 2;
        send(muldiv_pkg::op_rem, a, b);
        for (int n = 0; n < 3; n++) begin
            send(muldiv_pkg::op_mulh, a, b);
        end
        offer(muldiv_pkg::op_mulhsu, a, b);
        for (int n = 0; n < 40; n++) begin
            @(negedge clk);
            assert (!req_ready) else begin
                $display("req_ready went high with the commit port held off");
                stop_failed();
            end
        end
        bp_mode = 0;
        wait_accept();
        drain();

        $display("All checks passed");
        $finish;
    end

endmodule

// File: dv/muldiv_assert.sv
`timescale 1ns/100ps

module muldiv_assert (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           accept,
    input  logic                                           commit,
    input  logic [muldiv_pkg::mulq_bits-1:0]               new_tag,
    input  logic [muldiv_pkg::mulq_bits-1:0]               res_tag,
    input  logic                                           cmt_valid,
    input  logic                                           cmt_ready,
    input  logic [muldiv_pkg::meta_w+muldiv_pkg::num_lanes*32-1:0] cmt_rec
);

    logic                             seen_accept;
    logic [3:0]                       in_flight;
    logic [muldiv_pkg::mulq_size-1:0] live;
    logic [7:0]                       age [muldiv_pkg::mulq_size];
    logic                             too_old;

    logic fail_hold  = 1'b0;
    logic fail_idle  = 1'b0;
    logic fail_depth = 1'b0;
    logic fail_age   = 1'b0;
    logic any_failed;

    assign any_failed = fail_hold | fail_idle | fail_depth | fail_age;

    // Slot ages run from acceptance until the result loads the commit register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_accept <= 1'b0;
            in_flight   <= '0;
            live        <= '0;
            for (int i = 0; i < muldiv_pkg::mulq_size; i++) begin
                age[i] <= '0;
            end
        end else begin
            if (accept) begin
                seen_accept <= 1'b1;
                live[new_tag] <= 1'b1;
            end
            if (commit) begin
                live[res_tag] <= 1'b0;
            end
            in_flight <= in_flight + 4'(accept) - 4'(commit);
            for (int i = 0; i < muldiv_pkg::mulq_size; i++) begin
                age[i] <= live[i] ? age[i] + 8'd1 : 8'd0;
            end
        end
    end

    always_comb begin
        too_old = 1'b0;
        for (int i = 0; i < muldiv_pkg::mulq_size; i++) begin
            too_old = too_old | (age[i] >= 8'd200);
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_valid && !cmt_ready |=> cmt_valid && $stable(cmt_rec))
        else begin
            $error("Commit record changed while stalled");
            fail_hold = 1'b1;
        end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_accept |-> !cmt_valid)
        else begin
            $error("Commit valid before any request was accepted");
            fail_idle = 1'b1;
        end

    a_depth: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight <= 4'(muldiv_pkg::mulq_size))
        else begin
            $error("More requests in flight than tag slots");
            fail_depth = 1'b1;
        end

    a_age: assert property (@(posedge clk) disable iff (!rst_n) !too_old)
        else begin
            $error("Accepted request not committed within 200 cycles");
            fail_age = 1'b1;
        end

endmodule

bind muldiv_unit muldiv_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept    (accept),
    .commit    (commit),
    .new_tag   (new_tag),
    .res_tag   (res_tag),
    .cmt_valid (cmt_valid),
    .cmt_ready (cmt_ready),
    .cmt_rec   ({cmt_wid, cmt_tmask, cmt_pc, cmt_rd, cmt_wb, cmt_data})
);

// File: muldiv/muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit (
    input  logic                                    clk,
    input  logic                                    rst_n,

    // Request
    input  logic                                    req_valid,
    output logic                                    req_ready,
    input  muldiv_pkg::mul_op_t                     req_op,
    input  logic [muldiv_pkg::nw_bits-1:0]          req_wid,
    input  logic [muldiv_pkg::num_lanes-1:0]        req_tmask,
    input  logic [31:0]                             req_pc,
    input  logic [muldiv_pkg::nr_bits-1:0]          req_rd,
    input  logic                                    req_wb,
    input  logic [muldiv_pkg::num_lanes*32-1:0]     req_rs1,
    input  logic [muldiv_pkg::num_lanes*32-1:0]     req_rs2,

    // Commit
    output logic                                    cmt_valid,
    input  logic                                    cmt_ready,
    output logic [muldiv_pkg::nw_bits-1:0]          cmt_wid,
    output logic [muldiv_pkg::num_lanes-1:0]        cmt_tmask,
    output logic [31:0]                             cmt_pc,
    output logic [muldiv_pkg::nr_bits-1:0]          cmt_rd,
    output logic                                    cmt_wb,
    output logic [muldiv_pkg::num_lanes*32-1:0]     cmt_data
);

    logic is_div;
    logic signed_div;
    logic want_rem;
    logic stall;
    logic accept;

    logic                             tags_full;
    logic [muldiv_pkg::mulq_bits-1:0] new_tag;
    logic [muldiv_pkg::meta_w-1:0]    rsp_meta;

    logic                                mul_out_valid;
    logic [muldiv_pkg::mulq_bits-1:0]    mul_tag;
    logic [muldiv_pkg::num_lanes*32-1:0] mul_result;

    logic                                div_in_ready;
    logic                                div_out_valid;
    logic                                div_out_ready;
    logic [muldiv_pkg::mulq_bits-1:0]    div_tag;
    logic [muldiv_pkg::num_lanes*32-1:0] div_result;

    logic                                res_valid;
    logic [muldiv_pkg::mulq_bits-1:0]    res_tag;
    logic [muldiv_pkg::num_lanes*32-1:0] res_data;
    logic                                commit;

    assign is_div     = req_op[2];
    assign signed_div = (req_op == muldiv_pkg::op_div) || (req_op == muldiv_pkg::op_rem);
    assign want_rem   = (req_op == muldiv_pkg::op_rem) || (req_op == muldiv_pkg::op_remu);

    // Everything downstream keys off a held commit record
    assign stall     = cmt_valid && !cmt_ready;
    assign req_ready = !tags_full && !stall && (!is_div || div_in_ready);
    assign accept    = req_valid && req_ready;

    tag_buffer u_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .acquire      (accept),
        .write_data   ({req_wid, req_tmask, req_pc, req_rd, req_wb}),
        .write_addr   (new_tag),
        .full         (tags_full),
        .read_addr    (res_tag),
        .read_data    (rsp_meta),
        .release_slot (commit),
        .release_addr (res_tag)
    );

    mul_pipe u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (!stall),
        .in_valid  (accept && !is_div),
        .op        (req_op),
        .tag       (new_tag),
        .rs1       (req_rs1),
        .rs2       (req_rs2),
        .out_valid (mul_out_valid),
        .out_tag   (mul_tag),
        .result    (mul_result)
    );

    serial_div u_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (accept && is_div),
        .in_ready    (div_in_ready),
        .signed_mode (signed_div),
        .want_rem    (want_rem),
        .tag_in      (new_tag),
        .numer       (req_rs1),
        .denom       (req_rs2),
        .out_valid   (div_out_valid),
        .out_ready   (div_out_ready),
        .tag_out     (div_tag),
        .result      (div_result)
    );

    // Multiplier has fixed latency and cannot wait, so it wins the output
    assign div_out_ready = !stall && !mul_out_valid;

    assign res_valid = mul_out_valid || div_out_valid;
    assign res_tag   = mul_out_valid ? mul_tag : div_tag;
    assign res_data  = mul_out_valid ? mul_result : div_result;
    assign commit    = res_valid && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmt_valid <= 1'b0;
        end else if (!stall) begin
            cmt_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            {cmt_wid, cmt_tmask, cmt_pc, cmt_rd, cmt_wb} <= rsp_meta;
            cmt_data <= res_data;
        end
    end

endmodule

// File: muldiv/serial_div.sv
`timescale 1ns/100ps

module serial_div (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic                                    signed_mode,
    input  logic                                    want_rem,
    input  logic [muldiv_pkg::mulq_bits-1:0]        tag_in,
    input  logic [muldiv_pkg::num_lanes*32-1:0]     numer,
    input  logic [muldiv_pkg::num_lanes*32-1:0]     denom,

    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [muldiv_pkg::mulq_bits-1:0]        tag_out,
    output logic [muldiv_pkg::num_lanes*32-1:0]     result
);

    logic        busy;
    logic [5:0]  cnt;
    logic        want_rem_q;
    logic        load;
    logic        step;
    logic        last;

    logic [muldiv_pkg::num_lanes*32-1:0] fin;

    assign in_ready = !busy && !out_valid;
    assign load     = in_valid && in_ready;

    // cnt runs 0..31 while iterating, 32 means the fixup cycle
    assign step = busy && !cnt[5];
    assign last = busy && cnt[5];

    for (genvar i = 0; i < muldiv_pkg::num_lanes; i++) begin : g_lane
        logic [31:0] n_in;
        logic [31:0] d_in;
        logic [31:0] n_abs;
        logic [31:0] d_abs;

        logic [31:0] dvd_q;
        logic [31:0] den_q;
        logic [31:0] quo_q;
        logic [31:0] rem_q;
        logic        qneg_q;
        logic        rneg_q;
        logic        dz_q;
        logic        ov_q;

        logic [32:0] shifted;
        logic [32:0] diff;
        logic [31:0] q_fix;
        logic [31:0] r_fix;

        assign n_in  = numer[32*i +: 32];
        assign d_in  = denom[32*i +: 32];
        assign n_abs = (signed_mode && n_in[31]) ? -n_in : n_in;
        assign d_abs = (signed_mode && d_in[31]) ? -d_in : d_in;

        // Restoring step, a borrow out of bit 32 means no subtract
        assign shifted = {rem_q, quo_q[31]};
        assign diff    = shifted - {1'b0, den_q};

        always_ff @(posedge clk) begin
            if (load) begin
                dvd_q  <= n_in;
                den_q  <= d_abs;
                quo_q  <= n_abs;
                rem_q  <= '0;
                qneg_q <= signed_mode && (n_in[31] ^ d_in[31]);
                rneg_q <= signed_mode && n_in[31];
                dz_q   <= (d_in == '0);
                ov_q   <= signed_mode && (n_in == 32'h8000_0000) && (d_in == '1);
            end else if (step) begin
                quo_q <= {quo_q[30:0], ~diff[32]};
                rem_q <= diff[32] ? shifted[31:0] : diff[31:0];
            end
        end

        always_comb begin
            q_fix = qneg_q ? -quo_q : quo_q;
            r_fix = rneg_q ? -rem_q : rem_q;
            if (dz_q) begin
                q_fix = '1;
                r_fix = dvd_q;
            end else if (ov_q) begin
                q_fix = dvd_q;
                r_fix = '0;
            end
        end

        assign fin[32*i +: 32] = want_rem_q ? r_fix : q_fix;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            cnt       <= '0;
        end else begin
            if (load) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (last) begin
                busy      <= 1'b0;
                out_valid <= 1'b1;
            end else if (step) begin
                cnt <= cnt + 6'd1;
            end
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag_out    <= tag_in;
            want_rem_q <= want_rem;
        end
        if (last) begin
            result <= fin;
        end
    end

endmodule

// File: muldiv/mul_pipe.sv
`timescale 1ns/100ps

module mul_pipe (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    enable,

    input  logic                                    in_valid,
    input  muldiv_pkg::mul_op_t                     op,
    input  logic [muldiv_pkg::mulq_bits-1:0]        tag,
    input  logic [muldiv_pkg::num_lanes*32-1:0]     rs1,
    input  logic [muldiv_pkg::num_lanes*32-1:0]     rs2,

    output logic                                    out_valid,
    output logic [muldiv_pkg::mulq_bits-1:0]        out_tag,
    output logic [muldiv_pkg::num_lanes*32-1:0]     result
);

    localparam int lat = muldiv_pkg::mul_latency;

    logic a_signed;
    logic b_signed;

    logic [muldiv_pkg::num_lanes-1:0][63:0]          prod_d;
    logic [lat-1:0][muldiv_pkg::num_lanes-1:0][63:0] prod_q;
    logic [lat-1:0][muldiv_pkg::mulq_bits-1:0]       tag_q;
    logic [lat-1:0]                                  lo_q;
    logic [lat-1:0]                                  vld_q;

    // mulhsu keeps rs1 signed, only mul/mulh treat rs2 as signed
    assign a_signed = (op != muldiv_pkg::op_mulhu);
    assign b_signed = (op == muldiv_pkg::op_mul) || (op == muldiv_pkg::op_mulh);

    for (genvar i = 0; i < muldiv_pkg::num_lanes; i++) begin : g_lane
        logic signed [32:0] a;
        logic signed [32:0] b;

        assign a = {a_signed & rs1[32*i+31], rs1[32*i +: 32]};
        assign b = {b_signed & rs2[32*i+31], rs2[32*i +: 32]};

        // Low 64 bits of the 33x33 signed product are all that is needed
        assign prod_d[i] = 64'(a) * 64'(b);

        assign result[32*i +: 32] = lo_q[lat-1] ? prod_q[lat-1][i][31:0]
                                                : prod_q[lat-1][i][63:32];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (enable) begin
            vld_q <= {vld_q[lat-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            prod_q <= {prod_q[lat-2:0], prod_d};
            tag_q  <= {tag_q[lat-2:0], tag};
            lo_q   <= {lo_q[lat-2:0], op == muldiv_pkg::op_mul};
        end
    end

    assign out_valid = vld_q[lat-1];
    assign out_tag   = tag_q[lat-1];

endmodule

// File: rtl/tag_buffer.sv
`timescale 1ns/100ps

module tag_buffer (
    input  logic                             clk,
    input  logic                             rst_n,

    // Allocation side
    input  logic                             acquire,
    input  logic [muldiv_pkg::meta_w-1:0]    write_data,
    output logic [muldiv_pkg::mulq_bits-1:0] write_addr,
    output logic                             full,

    // Lookup and release side
    input  logic [muldiv_pkg::mulq_bits-1:0] read_addr,
    output logic [muldiv_pkg::meta_w-1:0]    read_data,
    input  logic                             release_slot,
    input  logic [muldiv_pkg::mulq_bits-1:0] release_addr
);

    logic [muldiv_pkg::mulq_size-1:0] used;
    logic [muldiv_pkg::mulq_size-1:0] used_nxt;
    logic [muldiv_pkg::meta_w-1:0]    slots [muldiv_pkg::mulq_size];

    // Lowest free slot becomes the next tag
    always_comb begin
        write_addr = '0;
        for (int i = muldiv_pkg::mulq_size - 1; i >= 0; i--) begin
            if (!used[i]) begin
                write_addr = muldiv_pkg::mulq_bits'(i);
            end
        end
    end

    assign full = &used;

    // The slot being released is always in use, so it never
    // collides with the free slot handed out in the same cycle
    always_comb begin
        used_nxt = used;
        if (release_slot) begin
            used_nxt[release_addr] = 1'b0;
        end
        if (acquire) begin
            used_nxt[write_addr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            used <= '0;
        end else begin
            used <= used_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            slots[write_addr] <= write_data;
        end
    end

    assign read_data = slots[read_addr];

endmodule

// File: common/muldiv_pkg.sv
package muldiv_pkg;

    // SIMD width and the per-warp fields carried with each request
    localparam int num_lanes = 4;
    localparam int nw_bits   = 2;
    localparam int nr_bits   = 5;

    // Tag buffer depth bounds the number of requests in flight
    localparam int mulq_size = 4;
    localparam int mulq_bits = $clog2(mulq_size);

    // Registered stages in the multiplier pipe
    localparam int mul_latency = 3;

    // Stored metadata is {wid, tmask, pc, rd, wb}
    localparam int meta_w = nw_bits + num_lanes + 32 + nr_bits + 1;

    // RISC-V M extension operations
    // Bit 2 set selects the divider path
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } mul_op_t;

endpackage
